// File: rtl/video_pkg.sv
package video_pkg;

    // ========================================================================
    // pixel format
    // ========================================================================
    localparam int COLOR_W = 8;             // per channel
    localparam int PIXEL_W = 3 * COLOR_W;   // r, g, b

    typedef struct packed {
        logic [COLOR_W-1:0] red;    // bits 23:16
        logic [COLOR_W-1:0] green;  // bits 15:8
        logic [COLOR_W-1:0] blue;   // bits 7:0
    } pixel_t;

    // ========================================================================
    // OSD palette
    // ========================================================================
    typedef logic [1:0] osd_color_t;

    // index 0..3
    localparam pixel_t OSD_BLACK  = pixel_t'(24'h000000);
    localparam pixel_t OSD_BLUE   = pixel_t'(24'h0000ff);
    localparam pixel_t OSD_YELLOW = pixel_t'(24'hffff00);  // full red + green
    localparam pixel_t OSD_WHITE  = pixel_t'(24'hffffff);

endpackage

// File: rtl/board_pkg.sv
package board_pkg;

    // ========================================================================
    // status side
    // ========================================================================

    // flops in the resync strobe synchronizer
    localparam int SYNC_STAGES = 2;

    // hold counter width on the board, about 0.6 s at 27 MHz
    localparam int LED_HOLD_W_DEF = 24;

endpackage

// File: rtl/video_if.sv
`timescale 1ns/1ns

interface video_if;
    import video_pkg::*;

    pixel_t pixel;  // packed rgb
    logic   hsync;  // active high
    logic   vsync;  // active high
    logic   de;

    // producer side
    modport src (
        output pixel,
        output hsync,
        output vsync,
        output de
    );

    // consumer side
    modport snk (
        input pixel,
        input hsync,
        input vsync,
        input de
    );

endinterface

// File: rtl/video_capture.sv
`timescale 1ns/1ns

module video_capture (
    input  logic                        clk27,
    input  logic                        sys_reset_n,
    input  logic [video_pkg::COLOR_W-1:0] r_i,
    input  logic [video_pkg::COLOR_W-1:0] g_i,
    input  logic [video_pkg::COLOR_W-1:0] b_i,
    input  logic                        hsync_i,
    input  logic                        vsync_i,
    input  logic                        de_i,
    input  logic                        hsync_pol_i,  // 1 = incoming hsync active low
    input  logic                        vsync_pol_i,  // 1 = incoming vsync active low
    video_if.src                        cap_o
);
    import video_pkg::*;

    pixel_t pix_in;

    assign pix_in = '{red: r_i, green: g_i, blue: b_i};

    // one register stage, syncs normalized to active high on the way in
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            cap_o.pixel <= '0;
            cap_o.hsync <= 1'b0;
            cap_o.vsync <= 1'b0;
            cap_o.de    <= 1'b0;
        end else begin
            cap_o.pixel <= pix_in;
            cap_o.hsync <= hsync_i ^ hsync_pol_i;  // invert when active low
            cap_o.vsync <= vsync_i ^ vsync_pol_i;
            cap_o.de    <= de_i;                   // never inverted
        end
    end

endmodule

// File: rtl/osd_palette.sv
`timescale 1ns/1ns

module osd_palette (
    input  logic                  clk27,
    input  logic                  sys_reset_n,
    input  logic                  osd_enable_i,
    input  video_pkg::osd_color_t osd_color_i,
    output logic                  osd_active_o,
    output video_pkg::pixel_t     osd_pixel_o
);
    import video_pkg::*;

    pixel_t color_lut;

    // fixed four entry palette
    always_comb begin
        case (osd_color_i)
            2'd0:    color_lut = OSD_BLACK;
            2'd1:    color_lut = OSD_BLUE;
            2'd2:    color_lut = OSD_YELLOW;
            default: color_lut = OSD_WHITE;
        endcase
    end

    // registered so it lines up with the captured pixel
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            osd_active_o <= 1'b0;
            osd_pixel_o  <= '0;
        end else begin
            osd_active_o <= osd_enable_i;
            osd_pixel_o  <= color_lut;
        end
    end

endmodule

// File: rtl/output_mixer.sv
`timescale 1ns/1ns

module output_mixer (
    input  logic              clk27,
    input  logic              sys_reset_n,
    video_if.snk              vid_i,
    input  logic              osd_active_i,
    input  video_pkg::pixel_t osd_pixel_i,
    output video_pkg::pixel_t tx_d_o,
    output logic              tx_hs_o,
    output logic              tx_vs_o,
    output logic              tx_de_o
);
    import video_pkg::*;

    pixel_t mix_q;
    logic   hs_q;
    logic   vs_q;
    logic   de_q;

    // ========================================================================
    // stage 1: osd overlay
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            mix_q <= '0;
            hs_q  <= 1'b0;
            vs_q  <= 1'b0;
            de_q  <= 1'b0;
        end else begin
            mix_q <= osd_active_i ? osd_pixel_i : vid_i.pixel;
            hs_q  <= vid_i.hsync;  // timing follows the video
            vs_q  <= vid_i.vsync;
            de_q  <= vid_i.de;
        end
    end

    // ========================================================================
    // stage 2: launch register toward the transmitter
    // ========================================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_d_o  <= '0;
            tx_hs_o <= 1'b0;
            tx_vs_o <= 1'b0;
            tx_de_o <= 1'b0;
        end else begin
            tx_d_o  <= mix_q;
            tx_hs_o <= hs_q;
            tx_vs_o <= vs_q;
            tx_de_o <= de_q;
        end
    end

endmodule

// File: rtl/resync_led.sv
`timescale 1ns/1ns

module resync_led #(
    parameter int LED_HOLD_W = board_pkg::LED_HOLD_W_DEF
) (
    input  logic clk27,
    input  logic sys_reset_n,
    input  logic resync_strobe_i,  // from another domain
    output logic led_o
);
    import board_pkg::*;

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   strobe_prev;
    logic                   strobe_rise;
    logic [LED_HOLD_W-1:0]  hold_cnt;

    // synchronizer plus one flop for edge detection
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sync_q      <= '0;
            strobe_prev <= 1'b0;
        end else begin
            sync_q      <= {sync_q[SYNC_STAGES-2:0], resync_strobe_i};
            strobe_prev <= sync_q[SYNC_STAGES-1];
        end
    end

    assign strobe_rise = sync_q[SYNC_STAGES-1] & ~strobe_prev;

    // stretch each rising edge, a new edge restarts the hold
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            hold_cnt <= '0;
        end else if (strobe_rise) begin
            hold_cnt <= '1;
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign led_o = (hold_cnt != '0);

endmodule

// File: rtl/scan_output_top.sv
`timescale 1ns/1ns

module scan_output_top #(
    parameter int LED_HOLD_W = board_pkg::LED_HOLD_W_DEF
) (
    input  logic                          clk27,
    input  logic                          sys_reset_n,
    // digitizer side
    input  logic [video_pkg::COLOR_W-1:0] r_i,
    input  logic [video_pkg::COLOR_W-1:0] g_i,
    input  logic [video_pkg::COLOR_W-1:0] b_i,
    input  logic                          hsync_i,
    input  logic                          vsync_i,
    input  logic                          de_i,
    // configuration levels
    input  logic                          hsync_pol_i,
    input  logic                          vsync_pol_i,
    // osd
    input  logic                          osd_enable_i,
    input  video_pkg::osd_color_t         osd_color_i,
    // status
    input  logic                          resync_strobe_i,
    // transmitter side
    output logic [video_pkg::PIXEL_W-1:0] tx_d_o,
    output logic                          tx_hs_o,
    output logic                          tx_vs_o,
    output logic                          tx_de_o,
    output logic                          led_o
);
    import video_pkg::*;

    // ========================================================================
    // video path
    // ========================================================================
    video_if cap_if ();

    logic   osd_active;
    pixel_t osd_pixel;

    video_capture u_capture (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .r_i         (r_i),
        .g_i         (g_i),
        .b_i         (b_i),
        .hsync_i     (hsync_i),
        .vsync_i     (vsync_i),
        .de_i        (de_i),
        .hsync_pol_i (hsync_pol_i),
        .vsync_pol_i (vsync_pol_i),
        .cap_o       (cap_if.src)
    );

    osd_palette u_palette (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .osd_active_o (osd_active),
        .osd_pixel_o  (osd_pixel)
    );

    output_mixer u_mixer (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .vid_i        (cap_if.snk),
        .osd_active_i (osd_active),
        .osd_pixel_i  (osd_pixel),
        .tx_d_o       (tx_d_o),    // packed rgb onto the 24-bit bus
        .tx_hs_o      (tx_hs_o),
        .tx_vs_o      (tx_vs_o),
        .tx_de_o      (tx_de_o)
    );

    // status led branch
    resync_led #(
        .LED_HOLD_W (LED_HOLD_W)
    ) u_resync_led (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (led_o)
    );

endmodule

// File: sim/scan_output_checker.sv
`timescale 1ns/1ns

module scan_output_checker (
    input logic                          clk27,
    input logic                          sys_reset_n,
    input logic                          de_i,
    input logic                          osd_enable_i,
    input video_pkg::osd_color_t         osd_color_i,
    input logic                          resync_strobe_i,
    input logic [video_pkg::PIXEL_W-1:0] tx_d_o,
    input logic                          tx_de_o,
    input logic                          led_o
);
    import video_pkg::*;
    import board_pkg::*;

    // input sampled at edge n is seen on tx outputs at edge n+3
    localparam int LAT = 3;

    logic [2:0] live_cnt;  // saturating count of edges since reset release

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            live_cnt <= '0;
        end else if (live_cnt < LAT) begin
            live_cnt <= live_cnt + 1'b1;
        end
    end

    function automatic pixel_t osd_lookup(input osd_color_t idx);
        case (idx)
            2'd0:    return OSD_BLACK;
            2'd1:    return OSD_BLUE;
            2'd2:    return OSD_YELLOW;
            default: return OSD_WHITE;
        endcase
    endfunction

    a_de_delay: assert property (@(posedge clk27) disable iff (!sys_reset_n)
        live_cnt == LAT |-> tx_de_o == $past(de_i, LAT))
        else $error("tx_de_o does not match de_i from three cycles back");

    a_osd_color: assert property (@(posedge clk27) disable iff (!sys_reset_n)
        (live_cnt == LAT) && $past(osd_enable_i, LAT)
        |-> tx_d_o == osd_lookup($past(osd_color_i, LAT)))
        else $error("tx_d_o is not the palette colour of an enabled osd pixel");

    // low in reset and one cycle after
    a_led_reset: assert property (@(posedge clk27) !sys_reset_n |=> !led_o)
        else $error("led_o high during or right after reset");

    a_led_rise: assert property (@(posedge clk27) disable iff (!sys_reset_n)
        $rose(led_o) |-> $past(resync_strobe_i, SYNC_STAGES + 1))
        else $error("led_o rose without a strobe through the synchronizer");

endmodule

// File: sim/tb_scan_output.sv
`timescale 1ns/1ns

module tb_scan_output;
    import video_pkg::*;

    localparam int LED_HOLD_W   = 6;
    localparam int LED_HOLD     = (1 << LED_HOLD_W) - 1;  // 63 cycles
    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = 2000;  // five tests of about 300 cycles plus margin

    typedef struct packed {
        logic [23:0] pix;
        logic        hs, vs, de;
        logic        hpol, vpol;
        logic        osd_en;
        logic [1:0]  osd_col;
        logic        strobe;
    } stim_t;

    typedef struct packed {
        logic [23:0] pix;
        logic        hs, vs, de;
    } exp_t;

    logic                 clk27;
    logic                 sys_reset_n;
    logic [COLOR_W-1:0]   r_i, g_i, b_i;
    logic                 hsync_i, vsync_i, de_i;
    logic                 hsync_pol_i, vsync_pol_i;
    logic                 osd_enable_i;
    osd_color_t           osd_color_i;
    logic                 resync_strobe_i;
    logic [PIXEL_W-1:0]   tx_d_o;
    logic                 tx_hs_o, tx_vs_o, tx_de_o;
    logic                 led_o;

    exp_t        exp_q[$];     // oldest first with three pixels in flight
    logic [3:0]  strobe_hist;  // [0] = strobe driven one cycle ago
    int          led_model;
    int          pix_errors, sync_errors, led_errors;
    int          cycle_cnt;
    int          led_high;
    logic        release_req;
    string       test_name;
    stim_t       s;

    scan_output_top #(.LED_HOLD_W(LED_HOLD_W)) uut (.*);

    bind scan_output_top scan_output_checker u_checker (.*);

    always #5 clk27 = ~clk27;

    always @(posedge clk27) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: test sequence still running after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic logic [23:0] palette_color(input logic [1:0] idx);
        case (idx)
            2'd0:    return 24'h000000;  // black
            2'd1:    return 24'h0000ff;  // blue
            2'd2:    return 24'hffff00;  // yellow
            default: return 24'hffffff;  // white
        endcase
    endfunction

    // random video with osd off and no strobe
    function automatic stim_t random_stim();
        stim_t r;
        r     = '0;
        r.pix = 24'($urandom);
        r.hs  = 1'($urandom);
        r.vs  = 1'($urandom);
        r.de  = 1'($urandom);
        return r;
    endfunction

    task automatic drive_cycle(input stim_t st);
        exp_t e;
        logic e_led;
        @(posedge clk27);
        #1;
        if (sys_reset_n) begin  // edge just taken was out of reset
            if (strobe_hist[2] && !strobe_hist[3])
                led_model = LED_HOLD;
            else if (led_model != 0)
                led_model = led_model - 1;
        end
        e_led = (led_model != 0);
        e     = exp_q.pop_front();
        if (tx_d_o !== e.pix) begin
            pix_errors++;
            $display("CHECK FAILED %s tx_d_o expected %h actual %h", test_name, e.pix, tx_d_o);
        end
        if (tx_hs_o !== e.hs) begin
            sync_errors++;
            $display("CHECK FAILED %s tx_hs_o expected %b actual %b", test_name, e.hs, tx_hs_o);
        end
        if (tx_vs_o !== e.vs) begin
            sync_errors++;
            $display("CHECK FAILED %s tx_vs_o expected %b actual %b", test_name, e.vs, tx_vs_o);
        end
        if (tx_de_o !== e.de) begin
            sync_errors++;
            $display("CHECK FAILED %s tx_de_o expected %b actual %b", test_name, e.de, tx_de_o);
        end
        if (led_o !== e_led) begin
            led_errors++;
            $display("CHECK FAILED %s led_o expected %b actual %b", test_name, e_led, led_o);
        end
        if (release_req) begin
            sys_reset_n = 1'b1;
            release_req = 1'b0;
        end
        {r_i, g_i, b_i}  = st.pix;
        hsync_i          = st.hs;
        vsync_i          = st.vs;
        de_i             = st.de;
        hsync_pol_i      = st.hpol;
        vsync_pol_i      = st.vpol;
        osd_enable_i     = st.osd_en;
        osd_color_i      = st.osd_col;
        resync_strobe_i  = st.strobe;
        strobe_hist      = {strobe_hist[2:0], st.strobe};
        if (!sys_reset_n) begin
            e = '0;  // sampled in reset so it never emerges
        end else begin
            e.pix = st.osd_en ? palette_color(st.osd_col) : st.pix;
            e.hs  = st.hpol ? ~st.hs : st.hs;  // polarity 1 means active low input
            e.vs  = st.vpol ? ~st.vs : st.vs;
            e.de  = st.de;
        end
        exp_q.push_back(e);
    endtask

    task automatic drain();
        repeat (4) drive_cycle('0);
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        logic hpol;
        logic vpol;
        clk27 = 1'b0;
        sys_reset_n = 1'b0;
        {r_i, g_i, b_i} = '0;
        {hsync_i, vsync_i, de_i, hsync_pol_i, vsync_pol_i} = '0;
        {osd_enable_i, osd_color_i, resync_strobe_i} = '0;
        {pix_errors, sync_errors, led_errors, cycle_cnt, led_model} = '0;
        strobe_hist = '0;
        release_req = 1'b0;
        repeat (3) exp_q.push_back('0);
        void'($urandom(32'h3dd9));

        test_name = "reset";
        repeat (RESET_CYCLES - 1) begin  // release lands in the drive slot of edge 10
            s = random_stim();
            s.osd_en = 1'($urandom);
            drive_cycle(s);
        end
        release_req = 1'b1;
        drain();

        test_name = "passthrough";
        repeat (300) drive_cycle(random_stim());
        drain();

        test_name = "polarity";
        repeat (10) begin
            hpol = 1'($urandom);
            vpol = 1'($urandom);
            repeat (30) begin
                s = random_stim();
                s.hpol = hpol;
                s.vpol = vpol;
                drive_cycle(s);
            end
        end
        drain();

        test_name = "osd_overlay";
        repeat (300) begin
            s = random_stim();
            s.osd_en  = 1'($urandom);
            s.osd_col = 2'($urandom);
            drive_cycle(s);
        end
        drain();

        test_name = "resync_led";
        repeat (60) drive_cycle(random_stim());
        led_high = 0;
        for (int i = 0; i < 80; i++) begin
            s = random_stim();
            s.strobe = (i == 0);
            drive_cycle(s);
            if (led_o) led_high++;
        end
        if (led_high != LED_HOLD) begin
            led_errors++;
            $display("CHECK FAILED %s single hold expected %0d actual %0d",
                     test_name, LED_HOLD, led_high);
        end
        led_high = 0;
        for (int i = 0; i < 130; i++) begin
            s = random_stim();
            s.strobe = (i == 0) || (i == 30);  // second load 30 cycles into the hold
            drive_cycle(s);
            if (led_o) led_high++;
        end
        if (led_high != LED_HOLD + 30) begin
            led_errors++;
            $display("CHECK FAILED %s extended hold expected %0d actual %0d",
                     test_name, LED_HOLD + 30, led_high);
        end
        repeat (60) drive_cycle(random_stim());
        drain();

        $display("errors: pixel %0d, sync %0d, led %0d", pix_errors, sync_errors, led_errors);
        if (pix_errors + sync_errors + led_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog.f
rtl/video_pkg.sv
rtl/board_pkg.sv
rtl/video_if.sv
rtl/video_capture.sv
rtl/osd_palette.sv
rtl/output_mixer.sv
rtl/resync_led.sv
rtl/scan_output_top.sv
sim/scan_output_checker.sv
sim/tb_scan_output.sv

// File: Bender.yml
package:
  name: scan_output

sources:
  - rtl/video_pkg.sv
  - rtl/board_pkg.sv
  - rtl/video_if.sv
  - rtl/video_capture.sv
  - rtl/osd_palette.sv
  - rtl/output_mixer.sv
  - rtl/resync_led.sv
  - rtl/scan_output_top.sv
  - target: simulation
    files:
      - sim/scan_output_checker.sv
      - sim/tb_scan_output.sv
